// ==== compile.f ====
+incdir+common
+incdir+tests
common/video_pkg.sv
common/regs_pkg.sv
hdl/gfx_regs.sv
hdl/frame_store.sv
blitter/rect_blitter.sv
video/video_timing.sv
video/pixel_scanout.sv
hdl/gfx_top.sv
tests/tb_gfx_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the gfx_top testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_gfx_top --Mdir obj_dir -o tb_gfx_top \
  -f compile.f

# a failing check ends in $fatal, which gives a non-zero exit status
./obj_dir/tb_gfx_top

// ==== tests/tb_gfx_model.svh ====
`ifndef TB_GFX_MODEL_SVH
`define TB_GFX_MODEL_SVH

// shadow of the frame store, kept by the host write and fill rules
video_pkg::pixel_word_u shadow [0:`GFX_FB_WORDS-1];

function automatic int pixel_index(int x, int y);
  return y * `GFX_H_REZ + x;  // y packed above x
endfunction

// inclusive fill, an inverted rectangle leaves the frame alone
function automatic void shadow_fill(int x1, int y1, int x2, int y2, logic [15:0] word);
  for (int y = y1; y <= y2; y++) begin
    for (int x = x1; x <= x2; x++) begin
      shadow[pixel_index(x, y)].raw = word;
    end
  end
endfunction

// rgb565 word to {red, green, blue} bytes, top bits repeated below
function automatic video_pkg::rgb888_t expand_rgb565(logic [15:0] word);
  int r;
  int g;
  int b;
  r = int'(word[4:0]);
  g = int'(word[10:5]);
  b = int'(word[15:11]);
  r = (r << 3) | (r >> 2);
  g = (g << 2) | (g >> 4);
  b = (b << 3) | (b >> 2);
  return video_pkg::rgb888_t'((r << 16) | (g << 8) | b);
endfunction

function automatic video_pkg::rgb888_t expected_rgb(int x, int y, logic en, int margin);
  if (!en || (x < margin) || (x >= `GFX_H_REZ) || (y >= `GFX_V_REZ)) begin
    return '0;  // black outside the image
  end
  return expand_rgb565(shadow[pixel_index(x - margin, y)].raw);
endfunction

// {hsync, vsync, blank} at a screen position
function automatic logic [2:0] expected_flags(int x, int y);
  logic hs;
  logic vs;
  logic bl;
  hs = (x >= `GFX_H_SYNC_START) && (x < `GFX_H_SYNC_END);
  vs = (y >= `GFX_V_SYNC_START) && (y < `GFX_V_SYNC_END);
  bl = !((x < `GFX_H_REZ) && (y < `GFX_V_REZ));
  return {hs, vs, bl};
endfunction

`endif

// ==== tests/tb_gfx_top.sv ====
`timescale 1ns/10ps
`include "gfx_defines.svh"

module tb_gfx_top;

  localparam int timeout_cycles = 2000;
  localparam int idle_cycles    = 20000;
  localparam int frame_cycles   = (`GFX_H_MAX + 1) * (`GFX_V_MAX + 1);

  logic                vga_clk;
  logic                arst_n_i;
  logic                reg_valid_i;
  logic                reg_write_i;
  regs_pkg::reg_addr_e reg_addr_i;
  regs_pkg::reg_data_t reg_wdata_i;
  logic                reg_ready_o;
  logic                reg_rvalid_o;
  regs_pkg::reg_data_t reg_rdata_o;
  video_pkg::rgb888_t  rgb_o;
  logic                hsync_o;
  logic                vsync_o;
  logic                blank_o;

  logic exp_en;            // display enable as the host last wrote it
  int   exp_margin;
  logic frame_req;
  int   frames_checked;
  int   last_write_waits;  // cycles with ready low on the last write

  `include "tb_gfx_model.svh"

  gfx_top i_gfx_top (
    .vga_clk      (vga_clk),
    .arst_n_i     (arst_n_i),
    .reg_valid_i  (reg_valid_i),
    .reg_write_i  (reg_write_i),
    .reg_addr_i   (reg_addr_i),
    .reg_wdata_i  (reg_wdata_i),
    .reg_ready_o  (reg_ready_o),
    .reg_rvalid_o (reg_rvalid_o),
    .reg_rdata_o  (reg_rdata_o),
    .rgb_o        (rgb_o),
    .hsync_o      (hsync_o),
    .vsync_o      (vsync_o),
    .blank_o      (blank_o)
  );

  initial begin
    vga_clk = 1'b0;
    forever #2 vga_clk = ~vga_clk;
  end

  // ------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------
  task automatic stop_on_failure(string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_rgb(string name, video_pkg::rgb888_t got, video_pkg::rgb888_t exp);
    if (got !== exp) begin
      stop_on_failure($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      stop_on_failure($sformatf("error at %0t: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_data(string name, regs_pkg::reg_data_t got, regs_pkg::reg_data_t exp);
    if (got !== exp) begin
      stop_on_failure($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  // ------------------------------------------------------------
  // host port
  // ------------------------------------------------------------
  task automatic wait_ready(output int waits);
    waits = 0;
    #1;  // ready settles after the falling-edge drive
    while (reg_ready_o !== 1'b1) begin
      waits++;
      if (waits > timeout_cycles) begin
        stop_on_failure("timeout: reg_ready_o stayed low");
      end
      @(negedge vga_clk);
      #1;
    end
  endtask

  task automatic write_reg(regs_pkg::reg_addr_e addr, regs_pkg::reg_data_t data);
    @(negedge vga_clk);
    reg_valid_i = 1'b1;
    reg_write_i = 1'b1;
    reg_addr_i  = addr;
    reg_wdata_i = data;
    wait_ready(last_write_waits);
    @(negedge vga_clk);  // taken on the rising edge before
    reg_valid_i = 1'b0;
    reg_write_i = 1'b0;
  endtask

  task automatic read_reg(regs_pkg::reg_addr_e addr, output regs_pkg::reg_data_t data);
    int n;
    @(negedge vga_clk);
    reg_valid_i = 1'b1;
    reg_write_i = 1'b0;
    reg_addr_i  = addr;
    wait_ready(n);
    @(negedge vga_clk);  // read data follows the accepting edge
    reg_valid_i = 1'b0;
    check_flag("reg_rvalid_o", reg_rvalid_o, 1'b1);
    data = reg_rdata_o;
  endtask

  task automatic check_read(regs_pkg::reg_addr_e addr, regs_pkg::reg_data_t exp);
    regs_pkg::reg_data_t got;
    read_reg(addr, got);
    check_data($sformatf("reg_rdata_o from 0x%h", addr), got, exp);
  endtask

  task automatic write_and_read_back(regs_pkg::reg_addr_e addr, int width);
    regs_pkg::reg_data_t wd;
    regs_pkg::reg_data_t mask;
    wd   = 16'($urandom);
    mask = (16'h1 << width) - 16'h1;  // only the field bits read back
    write_reg(addr, wd);
    check_read(addr, wd & mask);
  endtask

  task automatic write_pixel(int addr, regs_pkg::reg_data_t word);
    write_reg(regs_pkg::PIX_ADDR, regs_pkg::reg_data_t'(addr));
    write_reg(regs_pkg::PIX_DATA, word);
    shadow[addr].raw = word;
  endtask

  task automatic start_fill(int x1, int y1, int x2, int y2, regs_pkg::reg_data_t word);
    write_reg(regs_pkg::BLT_X1, regs_pkg::reg_data_t'(x1));
    write_reg(regs_pkg::BLT_Y1, regs_pkg::reg_data_t'(y1));
    write_reg(regs_pkg::BLT_X2, regs_pkg::reg_data_t'(x2));
    write_reg(regs_pkg::BLT_Y2, regs_pkg::reg_data_t'(y2));
    write_reg(regs_pkg::BLT_RGB, word);
    write_reg(regs_pkg::BLT_CTRL, 16'h0100);
    shadow_fill(x1, y1, x2, y2, word);
  endtask

  task automatic wait_fill_done();
    regs_pkg::reg_data_t status;
    int polls;
    polls = 0;
    read_reg(regs_pkg::BLT_CTRL, status);
    while (status != 16'h0000) begin
      check_data("BLT_CTRL while busy", status, 16'hffff);
      polls++;
      if (polls > timeout_cycles) begin
        stop_on_failure("timeout: the blitter stayed busy");
      end
      read_reg(regs_pkg::BLT_CTRL, status);
    end
  endtask

  // hands one frame to the compare process and waits for it
  task automatic check_frame();
    int done_before;
    int n;
    done_before = frames_checked;
    frame_req   = 1'b1;
    n           = 0;
    while (frames_checked == done_before) begin
      n++;
      if (n > 3 * frame_cycles) begin
        stop_on_failure("timeout: no frame was checked");
      end
      @(negedge vga_clk);
    end
    frame_req = 1'b0;
  endtask

  task automatic wait_for_level(bit on_blank, logic level);
    int n;
    n = 0;
    while ((on_blank ? blank_o : vsync_o) !== level) begin
      n++;
      if (n > 2 * frame_cycles) begin
        stop_on_failure("timeout: vsync_o or blank_o never reached the expected level");
      end
      @(negedge vga_clk);
    end
  endtask

  // ------------------------------------------------------------
  // compare process, one full frame per request
  // ------------------------------------------------------------
  initial begin : compare
    int n;
    logic [2:0] flags;
    frames_checked = 0;
    forever begin
      n = 0;
      while (frame_req !== 1'b1) begin
        n++;
        if (n > idle_cycles) begin
          stop_on_failure("timeout: the compare process got no frame request");
        end
        @(negedge vga_clk);
      end
      wait_for_level(1'b0, 1'b1);
      wait_for_level(1'b0, 1'b0);
      wait_for_level(1'b1, 1'b0);  // this output cycle is (0, 0)
      for (int y = 0; y <= `GFX_V_MAX; y++) begin
        for (int x = 0; x <= `GFX_H_MAX; x++) begin
          flags = expected_flags(x, y);
          check_rgb($sformatf("rgb_o at (%0d, %0d)", x, y), rgb_o,
                    expected_rgb(x, y, exp_en, exp_margin));
          check_flag($sformatf("hsync_o at (%0d, %0d)", x, y), hsync_o, flags[2]);
          check_flag($sformatf("vsync_o at (%0d, %0d)", x, y), vsync_o, flags[1]);
          check_flag($sformatf("blank_o at (%0d, %0d)", x, y), blank_o, flags[0]);
          @(negedge vga_clk);
        end
      end
      frames_checked++;
      n = 0;
      while (frame_req === 1'b1) begin
        n++;
        if (n > timeout_cycles) begin
          stop_on_failure("timeout: the frame request was never withdrawn");
        end
        @(negedge vga_clk);
      end
    end
  end

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  initial begin : stimulus
    int x1;
    int x2;
    int y1;
    int y2;
    void'($urandom(32'h31ce_5ab1));
    arst_n_i    = 1'b0;
    reg_valid_i = 1'b0;
    reg_write_i = 1'b0;
    reg_addr_i  = regs_pkg::CTRL;
    reg_wdata_i = '0;
    frame_req   = 1'b0;
    exp_en      = 1'b1;
    exp_margin  = 0;
    repeat (2) @(negedge vga_clk);

    // outputs while reset is held
    check_flag("reg_ready_o in reset", reg_ready_o, 1'b1);
    check_flag("reg_rvalid_o in reset", reg_rvalid_o, 1'b0);
    check_flag("hsync_o in reset", hsync_o, 1'b0);
    check_flag("vsync_o in reset", vsync_o, 1'b0);
    check_flag("blank_o in reset", blank_o, 1'b1);
    check_rgb("rgb_o in reset", rgb_o, '0);
    arst_n_i = 1'b1;

    // register read-back
    check_read(regs_pkg::CTRL, 16'h0001);
    write_and_read_back(regs_pkg::CTRL, 1);
    write_and_read_back(regs_pkg::MARGIN_X, 6);
    write_and_read_back(regs_pkg::BLT_X1, 6);
    write_and_read_back(regs_pkg::BLT_Y1, 4);
    write_and_read_back(regs_pkg::BLT_X2, 6);
    write_and_read_back(regs_pkg::BLT_Y2, 4);
    write_and_read_back(regs_pkg::BLT_RGB, 16);
    write_and_read_back(regs_pkg::PIX_ADDR, 8);
    check_read(regs_pkg::reg_addr_e'(8'h10), 16'h0000);
    write_reg(regs_pkg::CTRL, 16'h0001);
    write_reg(regs_pkg::MARGIN_X, 16'h0000);

    // every pixel from the host
    for (int a = 0; a < `GFX_FB_WORDS; a++) begin
      write_pixel(a, 16'($urandom));
    end
    check_frame();

    // empty fill first, then a random one
    start_fill(20, 2, 10, 5, 16'($urandom));
    wait_fill_done();
    x1 = $urandom_range(31, 0);
    x2 = $urandom_range(31, x1);
    y1 = $urandom_range(7, 0);
    y2 = $urandom_range(7, y1);
    start_fill(x1, y1, x2, y2, 16'($urandom));
    wait_fill_done();
    check_frame();

    // host writes stall a running fill, second start waits
    start_fill($urandom_range(5, 2), 1, $urandom_range(28, 24), $urandom_range(6, 5),
               16'($urandom));
    write_pixel(pixel_index(0, 0), 16'($urandom));
    write_pixel(pixel_index(31, 7), 16'($urandom));
    x1 = $urandom_range(12, 6);
    y1 = $urandom_range(3, 2);
    start_fill(x1, y1, $urandom_range(x1 + 8, x1), $urandom_range(4, y1), 16'($urandom));
    if (last_write_waits == 0) begin
      stop_on_failure("reg_ready_o stayed high for a start while the blitter was busy");
    end
    wait_fill_done();
    check_frame();

    // margin, then display off
    write_reg(regs_pkg::MARGIN_X, 16'h0003);
    exp_margin = 3;
    check_frame();
    write_reg(regs_pkg::CTRL, 16'h0000);
    exp_en = 1'b0;
    check_frame();

    $display("Testbench passed");
    $finish;
  end

endmodule

// ==== hdl/gfx_top.sv ====
`timescale 1ns/10ps

module gfx_top (
  input  logic                vga_clk,
  input  logic                arst_n_i,
  input  logic                reg_valid_i,
  input  logic                reg_write_i,
  input  regs_pkg::reg_addr_e reg_addr_i,
  input  regs_pkg::reg_data_t reg_wdata_i,
  output logic                reg_ready_o,
  output logic                reg_rvalid_o,
  output regs_pkg::reg_data_t reg_rdata_o,
  output video_pkg::rgb888_t  rgb_o,
  output logic                hsync_o,
  output logic                vsync_o,
  output logic                blank_o
);

  logic                   display_en;
  video_pkg::coord_x_t    margin_x;
  logic                   pix_we;
  video_pkg::fb_addr_t    pix_addr;
  video_pkg::pixel_word_u pix_data;

  logic                   blt_start;
  video_pkg::coord_x_t    blt_x1;
  video_pkg::coord_x_t    blt_x2;
  video_pkg::coord_y_t    blt_y1;
  video_pkg::coord_y_t    blt_y2;
  video_pkg::pixel_word_u blt_rgb;
  logic                   blt_busy;
  logic                   blt_we;
  logic                   blt_stall;
  video_pkg::fb_addr_t    blt_addr;
  video_pkg::pixel_word_u blt_data;

  video_pkg::fb_addr_t    rd_addr;
  video_pkg::pixel_word_u rd_data;
  video_pkg::coord_x_t    counter_x;
  video_pkg::coord_y_t    counter_y;
  logic                   tim_hsync;
  logic                   tim_vsync;
  logic                   tim_blank;

  gfx_regs i_gfx_regs (
    .vga_clk      (vga_clk),
    .arst_n_i     (arst_n_i),
    .reg_valid_i  (reg_valid_i),
    .reg_write_i  (reg_write_i),
    .reg_addr_i   (reg_addr_i),
    .reg_wdata_i  (reg_wdata_i),
    .blt_busy_i   (blt_busy),
    .reg_ready_o  (reg_ready_o),
    .reg_rvalid_o (reg_rvalid_o),
    .reg_rdata_o  (reg_rdata_o),
    .display_en_o (display_en),
    .margin_x_o   (margin_x),
    .pix_we_o     (pix_we),
    .pix_addr_o   (pix_addr),
    .pix_data_o   (pix_data),
    .blt_start_o  (blt_start),
    .blt_x1_o     (blt_x1),
    .blt_x2_o     (blt_x2),
    .blt_y1_o     (blt_y1),
    .blt_y2_o     (blt_y2),
    .blt_rgb_o    (blt_rgb)
  );

  rect_blitter i_rect_blitter (
    .vga_clk  (vga_clk),
    .arst_n_i (arst_n_i),
    .start_i  (blt_start),
    .x1_i     (blt_x1),
    .x2_i     (blt_x2),
    .y1_i     (blt_y1),
    .y2_i     (blt_y2),
    .rgb_i    (blt_rgb),
    .stall_i  (blt_stall),
    .busy_o   (blt_busy),
    .we_o     (blt_we),
    .addr_o   (blt_addr),
    .data_o   (blt_data)
  );

  frame_store i_frame_store (
    .vga_clk     (vga_clk),
    .host_we_i   (pix_we),
    .host_addr_i (pix_addr),
    .host_data_i (pix_data),
    .blt_we_i    (blt_we),
    .blt_addr_i  (blt_addr),
    .blt_data_i  (blt_data),
    .rd_addr_i   (rd_addr),
    .blt_stall_o (blt_stall),
    .rd_data_o   (rd_data)
  );

  video_timing i_video_timing (
    .vga_clk     (vga_clk),
    .arst_n_i    (arst_n_i),
    .counter_x_o (counter_x),
    .counter_y_o (counter_y),
    .hsync_o     (tim_hsync),
    .vsync_o     (tim_vsync),
    .blank_o     (tim_blank)
  );

  pixel_scanout i_pixel_scanout (
    .vga_clk      (vga_clk),
    .arst_n_i     (arst_n_i),
    .counter_x_i  (counter_x),
    .counter_y_i  (counter_y),
    .hsync_i      (tim_hsync),
    .vsync_i      (tim_vsync),
    .blank_i      (tim_blank),
    .display_en_i (display_en),
    .margin_x_i   (margin_x),
    .rd_data_i    (rd_data),
    .rd_addr_o    (rd_addr),
    .rgb_o        (rgb_o),
    .hsync_o      (hsync_o),
    .vsync_o      (vsync_o),
    .blank_o      (blank_o)
  );

endmodule

// ==== video/pixel_scanout.sv ====
`timescale 1ns/10ps
`include "gfx_defines.svh"

module pixel_scanout (
  input  logic                   vga_clk,
  input  logic                   arst_n_i,
  input  video_pkg::coord_x_t    counter_x_i,
  input  video_pkg::coord_y_t    counter_y_i,
  input  logic                   hsync_i,
  input  logic                   vsync_i,
  input  logic                   blank_i,
  input  logic                   display_en_i,
  input  video_pkg::coord_x_t    margin_x_i,
  input  video_pkg::pixel_word_u rd_data_i,
  output video_pkg::fb_addr_t    rd_addr_o,
  output video_pkg::rgb888_t     rgb_o,
  output logic                   hsync_o,
  output logic                   vsync_o,
  output logic                   blank_o
);

  localparam video_pkg::coord_x_t h_rez = video_pkg::coord_x_t'(`GFX_H_REZ);
  localparam video_pkg::coord_y_t v_rez = video_pkg::coord_y_t'(`GFX_V_REZ);

  video_pkg::coord_x_t col;
  logic                show;
  logic                show_q;  // lines up with rd_data_i
  logic [7:0]          red8;
  logic [7:0]          green8;
  logic [7:0]          blue8;

  // ------------------------------------------------------------
  // stage 0, address and pixel/black decision
  // ------------------------------------------------------------
  assign col       = counter_x_i - margin_x_i;
  assign rd_addr_o = video_pkg::fb_addr_t'({counter_y_i, col[`GFX_FB_X_BITS-1:0]});
  assign show      = display_en_i && (counter_x_i >= margin_x_i) &&
                     (counter_x_i < h_rez) && (counter_y_i < v_rez);

  // top bits copied down so full scale gives 0xff
  assign red8   = {rd_data_i.rgb.red, rd_data_i.rgb.red[4:2]};
  assign green8 = {rd_data_i.rgb.green, rd_data_i.rgb.green[5:4]};
  assign blue8  = {rd_data_i.rgb.blue, rd_data_i.rgb.blue[4:2]};

  // ------------------------------------------------------------
  // stage 1, expansion and sync alignment
  // ------------------------------------------------------------
  always_ff @(posedge vga_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      show_q  <= 1'b0;
      rgb_o   <= '0;
      hsync_o <= 1'b0;
      vsync_o <= 1'b0;
      blank_o <= 1'b1;
    end else begin
      show_q  <= show;
      rgb_o   <= show_q ? {red8, green8, blue8} : '0;
      hsync_o <= hsync_i;  // already one cycle behind the counters
      vsync_o <= vsync_i;
      blank_o <= blank_i;
    end
  end

  // timing blank and scanout decision agree
  a_black_in_blank : assert property (@(posedge vga_clk) disable iff (!arst_n_i)
    blank_o |-> rgb_o == '0);

endmodule

// ==== video/video_timing.sv ====
`timescale 1ns/10ps
`include "gfx_defines.svh"

module video_timing (
  input  logic                vga_clk,
  input  logic                arst_n_i,
  output video_pkg::coord_x_t counter_x_o,
  output video_pkg::coord_y_t counter_y_o,
  output logic                hsync_o,
  output logic                vsync_o,
  output logic                blank_o
);

  localparam video_pkg::coord_x_t h_rez        = video_pkg::coord_x_t'(`GFX_H_REZ);
  localparam video_pkg::coord_x_t h_sync_start = video_pkg::coord_x_t'(`GFX_H_SYNC_START);
  localparam video_pkg::coord_x_t h_sync_end   = video_pkg::coord_x_t'(`GFX_H_SYNC_END);
  localparam video_pkg::coord_x_t h_max        = video_pkg::coord_x_t'(`GFX_H_MAX);
  localparam video_pkg::coord_y_t v_rez        = video_pkg::coord_y_t'(`GFX_V_REZ);
  localparam video_pkg::coord_y_t v_sync_start = video_pkg::coord_y_t'(`GFX_V_SYNC_START);
  localparam video_pkg::coord_y_t v_sync_end   = video_pkg::coord_y_t'(`GFX_V_SYNC_END);
  localparam video_pkg::coord_y_t v_max        = video_pkg::coord_y_t'(`GFX_V_MAX);

  always_ff @(posedge vga_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      counter_x_o <= '0;
      counter_y_o <= '0;
      hsync_o     <= 1'b0;
      vsync_o     <= 1'b0;
      blank_o     <= 1'b1;
    end else begin
      if (counter_x_o == h_max) begin
        counter_x_o <= '0;
        counter_y_o <= (counter_y_o == v_max) ? '0 : counter_y_o + 1'b1;
      end else begin
        counter_x_o <= counter_x_o + 1'b1;
      end

      // flags trail the counters by one cycle
      hsync_o <= (counter_x_o >= h_sync_start) && (counter_x_o < h_sync_end);
      vsync_o <= (counter_y_o >= v_sync_start) && (counter_y_o < v_sync_end);
      blank_o <= !((counter_x_o < h_rez) && (counter_y_o < v_rez));
    end
  end

  a_x_range : assert property (@(posedge vga_clk) disable iff (!arst_n_i)
    counter_x_o <= h_max);

endmodule

// ==== blitter/rect_blitter.sv ====
`timescale 1ns/10ps
`include "gfx_defines.svh"

module rect_blitter (
  input  logic                   vga_clk,
  input  logic                   arst_n_i,
  input  logic                   start_i,
  input  video_pkg::coord_x_t    x1_i,
  input  video_pkg::coord_x_t    x2_i,
  input  video_pkg::coord_y_t    y1_i,
  input  video_pkg::coord_y_t    y2_i,
  input  video_pkg::pixel_word_u rgb_i,
  input  logic                   stall_i,
  output logic                   busy_o,
  output logic                   we_o,
  output video_pkg::fb_addr_t    addr_o,
  output video_pkg::pixel_word_u data_o
);

  video_pkg::coord_x_t x1_q;
  video_pkg::coord_x_t x2_q;
  video_pkg::coord_y_t y2_q;
  video_pkg::coord_x_t cur_x;
  video_pkg::coord_y_t cur_y;
  logic                empty_q;  // inverted rectangle, nothing to write
  logic                last_col;
  logic                last_row;

  assign last_col = (cur_x == x2_q);
  assign last_row = (cur_y == y2_q);
  assign we_o     = busy_o && !empty_q;
  assign addr_o   = video_pkg::fb_addr_t'({cur_y, cur_x[`GFX_FB_X_BITS-1:0]});

  // rectangle and colour, held for the whole fill
  always_ff @(posedge vga_clk) begin
    if (start_i && !busy_o) begin
      x1_q   <= x1_i;
      x2_q   <= x2_i;
      y2_q   <= y2_i;
      data_o <= rgb_i;
    end
  end

  // ------------------------------------------------------------
  // row-major walk
  // ------------------------------------------------------------
  always_ff @(posedge vga_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_o  <= 1'b0;
      empty_q <= 1'b0;
      cur_x   <= '0;
      cur_y   <= '0;
    end else if (start_i && !busy_o) begin
      busy_o  <= 1'b1;
      empty_q <= (x2_i < x1_i) || (y2_i < y1_i);
      cur_x   <= x1_i;
      cur_y   <= y1_i;
    end else if (busy_o && (empty_q || !stall_i)) begin  // stalled pixel is retried
      if (empty_q || (last_col && last_row)) begin
        busy_o <= 1'b0;
      end else if (last_col) begin
        cur_x <= x1_q;
        cur_y <= cur_y + 1'b1;
      end else begin
        cur_x <= cur_x + 1'b1;
      end
    end
  end

  // every write lands inside the latched rectangle
  a_write_in_rect : assert property (@(posedge vga_clk) disable iff (!arst_n_i)
    we_o |-> busy_o && (cur_x >= x1_q) && (cur_x <= x2_q) && (cur_y <= y2_q));

endmodule

// ==== hdl/frame_store.sv ====
`timescale 1ns/10ps
`include "gfx_defines.svh"

module frame_store (
  input  logic                   vga_clk,
  input  logic                   host_we_i,
  input  video_pkg::fb_addr_t    host_addr_i,
  input  video_pkg::pixel_word_u host_data_i,
  input  logic                   blt_we_i,
  input  video_pkg::fb_addr_t    blt_addr_i,
  input  video_pkg::pixel_word_u blt_data_i,
  input  video_pkg::fb_addr_t    rd_addr_i,
  output logic                   blt_stall_o,
  output video_pkg::pixel_word_u rd_data_o
);

  video_pkg::pixel_word_u mem [0:`GFX_FB_WORDS-1];

  logic                   wr_en;
  video_pkg::fb_addr_t    wr_addr;
  video_pkg::pixel_word_u wr_data;

  // single write port, host has priority
  assign blt_stall_o = host_we_i && blt_we_i;
  assign wr_en       = host_we_i || blt_we_i;
  assign wr_addr     = host_we_i ? host_addr_i : blt_addr_i;
  assign wr_data     = host_we_i ? host_data_i : blt_data_i;

  always_ff @(posedge vga_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    rd_data_o <= mem[rd_addr_i];  // scanout port, 1 cycle
  end

endmodule

// ==== hdl/gfx_regs.sv ====
`timescale 1ns/10ps
`include "gfx_defines.svh"

module gfx_regs (
  input  logic                   vga_clk,
  input  logic                   arst_n_i,
  input  logic                   reg_valid_i,
  input  logic                   reg_write_i,
  input  regs_pkg::reg_addr_e    reg_addr_i,
  input  regs_pkg::reg_data_t    reg_wdata_i,
  input  logic                   blt_busy_i,
  output logic                   reg_ready_o,
  output logic                   reg_rvalid_o,
  output regs_pkg::reg_data_t    reg_rdata_o,
  output logic                   display_en_o,
  output video_pkg::coord_x_t    margin_x_o,
  output logic                   pix_we_o,
  output video_pkg::fb_addr_t    pix_addr_o,
  output video_pkg::pixel_word_u pix_data_o,
  output logic                   blt_start_o,
  output video_pkg::coord_x_t    blt_x1_o,
  output video_pkg::coord_x_t    blt_x2_o,
  output video_pkg::coord_y_t    blt_y1_o,
  output video_pkg::coord_y_t    blt_y2_o,
  output video_pkg::pixel_word_u blt_rgb_o
);

  logic blt_pending;  // busy, or a start still on its way to the blitter
  logic start_req;
  logic wr_acc;
  logic rd_acc;

  // ------------------------------------------------------------
  // host handshake
  // ------------------------------------------------------------
  assign blt_pending = blt_busy_i | blt_start_o;
  assign start_req   = reg_valid_i && reg_write_i && (reg_addr_i == regs_pkg::BLT_CTRL) &&
                       reg_wdata_i[`GFX_BLT_START_BIT];
  assign reg_ready_o = !(start_req && blt_pending);  // a new start waits for the fill
  assign wr_acc      = reg_valid_i && reg_ready_o && reg_write_i;
  assign rd_acc      = reg_valid_i && reg_ready_o && !reg_write_i;

  always_ff @(posedge vga_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      display_en_o <= `GFX_CTRL_RESET;
      margin_x_o   <= '0;
      pix_we_o     <= 1'b0;
      blt_start_o  <= 1'b0;
      reg_rvalid_o <= 1'b0;
    end else begin
      pix_we_o     <= wr_acc && (reg_addr_i == regs_pkg::PIX_DATA);
      blt_start_o  <= wr_acc && start_req;
      reg_rvalid_o <= rd_acc;
      if (wr_acc && (reg_addr_i == regs_pkg::CTRL)) begin
        display_en_o <= reg_wdata_i[0];
      end
      if (wr_acc && (reg_addr_i == regs_pkg::MARGIN_X)) begin
        margin_x_o <= video_pkg::coord_x_t'(reg_wdata_i);
      end
    end
  end

  // ------------------------------------------------------------
  // blitter and pixel payload, read mux
  // ------------------------------------------------------------
  always_ff @(posedge vga_clk) begin
    if (wr_acc) begin
      case (reg_addr_i)
        regs_pkg::BLT_X1:   blt_x1_o       <= video_pkg::coord_x_t'(reg_wdata_i);
        regs_pkg::BLT_Y1:   blt_y1_o       <= video_pkg::coord_y_t'(reg_wdata_i);
        regs_pkg::BLT_X2:   blt_x2_o       <= video_pkg::coord_x_t'(reg_wdata_i);
        regs_pkg::BLT_Y2:   blt_y2_o       <= video_pkg::coord_y_t'(reg_wdata_i);
        regs_pkg::BLT_RGB:  blt_rgb_o.raw  <= reg_wdata_i;
        regs_pkg::PIX_ADDR: pix_addr_o     <= video_pkg::fb_addr_t'(reg_wdata_i);
        regs_pkg::PIX_DATA: pix_data_o.raw <= reg_wdata_i;  // stored next cycle
        default: ;
      endcase
    end
    if (rd_acc) begin
      case (reg_addr_i)
        regs_pkg::CTRL:     reg_rdata_o <= regs_pkg::reg_data_t'(display_en_o);
        regs_pkg::MARGIN_X: reg_rdata_o <= regs_pkg::reg_data_t'(margin_x_o);
        regs_pkg::BLT_X1:   reg_rdata_o <= regs_pkg::reg_data_t'(blt_x1_o);
        regs_pkg::BLT_Y1:   reg_rdata_o <= regs_pkg::reg_data_t'(blt_y1_o);
        regs_pkg::BLT_X2:   reg_rdata_o <= regs_pkg::reg_data_t'(blt_x2_o);
        regs_pkg::BLT_Y2:   reg_rdata_o <= regs_pkg::reg_data_t'(blt_y2_o);
        regs_pkg::BLT_RGB:  reg_rdata_o <= blt_rgb_o.raw;
        regs_pkg::BLT_CTRL: reg_rdata_o <= blt_pending ? 16'hffff : 16'h0000;
        regs_pkg::PIX_ADDR: reg_rdata_o <= regs_pkg::reg_data_t'(pix_addr_o);
        default:            reg_rdata_o <= '0;  // no pixel read-back
      endcase
    end
  end

  // start reaches an idle blitter, once
  a_start_pulse : assert property (@(posedge vga_clk) disable iff (!arst_n_i)
    blt_start_o |-> !blt_busy_i ##1 !blt_start_o);

endmodule

// ==== common/regs_pkg.sv ====
package regs_pkg;

  // host register map, byte addresses
  typedef enum logic [7:0] {
    CTRL     = 8'h00,  // bit 0 display enable
    MARGIN_X = 8'h06,
    BLT_X1   = 8'h20,
    BLT_Y1   = 8'h22,
    BLT_X2   = 8'h24,
    BLT_Y2   = 8'h26,
    BLT_RGB  = 8'h28,
    BLT_CTRL = 8'h2a,  // write bit 8 to start, reads busy
    PIX_ADDR = 8'h2c,
    PIX_DATA = 8'h2e   // write only
  } reg_addr_e;

  typedef logic [15:0] reg_data_t;

endpackage

// ==== common/video_pkg.sv ====
`include "gfx_defines.svh"

package video_pkg;

  // screen counters
  typedef logic [`GFX_X_BITS-1:0] coord_x_t;
  typedef logic [`GFX_Y_BITS-1:0] coord_y_t;

  typedef logic [$clog2(`GFX_FB_WORDS)-1:0] fb_addr_t;

  // rgb565 with red in the low bits
  typedef struct packed {
    logic [4:0] blue;
    logic [5:0] green;
    logic [4:0] red;
  } rgb565_t;

  // host and memory move raw words, scanout looks at the fields
  typedef union packed {
    rgb565_t     rgb;
    logic [15:0] raw;
  } pixel_word_u;

  typedef logic [23:0] rgb888_t;  // {red, green, blue}

endpackage

// ==== common/gfx_defines.svh ====
`ifndef GFX_DEFINES_SVH
`define GFX_DEFINES_SVH

// ------------------------------------------------------------
// frame geometry, reduced for simulation
// ------------------------------------------------------------
`define GFX_H_REZ         32
`define GFX_H_SYNC_START  36
`define GFX_H_SYNC_END    40
`define GFX_H_MAX         47

`define GFX_V_REZ         8
`define GFX_V_SYNC_START  9
`define GFX_V_SYNC_END    11
`define GFX_V_MAX         12

`define GFX_X_BITS        6
`define GFX_Y_BITS        4
`define GFX_FB_X_BITS     5   // y sits above x in a frame-store address
`define GFX_FB_WORDS      256

// ------------------------------------------------------------
// register fields
// ------------------------------------------------------------
`define GFX_CTRL_RESET    1'b1  // display enabled out of reset
`define GFX_BLT_START_BIT 8

`endif
